/* src/lc4_pkg.sv */
`default_nettype none

package lc4_pkg;

    // datapath and register file sizing
    localparam int XLEN     = 16;
    localparam int REG_AW   = 3;
    localparam int NUM_REGS = 8;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 16'h8200;

    // LC4 primary opcodes, insn[15:12]
    typedef enum logic [3:0] {
        OPC_BR      = 4'b0000,
        OPC_ARITH   = 4'b0001,
        OPC_CMP     = 4'b0010,
        OPC_JSRX    = 4'b0100,
        OPC_LOGIC   = 4'b0101,
        OPC_LDR     = 4'b0110,
        OPC_STR     = 4'b0111,
        OPC_RTI     = 4'b1000,
        OPC_CONST   = 4'b1001,
        OPC_SHIFT   = 4'b1010,
        OPC_JMPX    = 4'b1100,
        OPC_HICONST = 4'b1101,
        OPC_TRAP    = 4'b1111
    } opcode_e;

    // operations the execute lanes actually perform
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_MUL,
        OP_SUB,
        OP_ADDI,
        OP_AND,
        OP_NOT,
        OP_OR,
        OP_XOR,
        OP_ANDI,
        OP_CONST,
        OP_HICONST,
        OP_SLL,
        OP_SRA,
        OP_SRL
    } alu_op_e;

    // one decoded instruction
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   insn;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic              rs_re;
        logic              rt_re;
        logic [REG_AW-1:0] rd;
        logic              rd_we;
        alu_op_e           alu_op;
    } uop_t;

    // one completed instruction, also the register file write request
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   insn;
        logic [REG_AW-1:0] rd;
        logic              rd_we;
        logic [XLEN-1:0]   data;
    } retire_t;

endpackage

`default_nettype wire

/* src/lc4_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder (
    input  wire logic [lc4_pkg::XLEN-1:0] i_insn,
    input  wire logic [lc4_pkg::XLEN-1:0] i_pc,
    output lc4_pkg::uop_t                 o_uop
);

    lc4_pkg::opcode_e opcode;
    lc4_pkg::alu_op_e op;

    assign opcode = lc4_pkg::opcode_e'(i_insn[15:12]);

    // pick the operation, anything outside the kept group is a nop
    always_comb begin
        op = lc4_pkg::OP_NOP;
        case (opcode)
            lc4_pkg::OPC_ARITH: begin
                if (i_insn[5]) begin
                    op = lc4_pkg::OP_ADDI;
                end else begin
                    case (i_insn[4:3])
                        2'b00:   op = lc4_pkg::OP_ADD;
                        2'b01:   op = lc4_pkg::OP_MUL;
                        2'b10:   op = lc4_pkg::OP_SUB;
                        // DIV is not implemented
                        default: op = lc4_pkg::OP_NOP;
                    endcase
                end
            end
            lc4_pkg::OPC_LOGIC: begin
                if (i_insn[5]) begin
                    op = lc4_pkg::OP_ANDI;
                end else begin
                    case (i_insn[4:3])
                        2'b00:   op = lc4_pkg::OP_AND;
                        2'b01:   op = lc4_pkg::OP_NOT;
                        2'b10:   op = lc4_pkg::OP_OR;
                        default: op = lc4_pkg::OP_XOR;
                    endcase
                end
            end
            lc4_pkg::OPC_CONST:   op = lc4_pkg::OP_CONST;
            lc4_pkg::OPC_HICONST: op = lc4_pkg::OP_HICONST;
            lc4_pkg::OPC_SHIFT: begin
                case (i_insn[5:4])
                    2'b00:   op = lc4_pkg::OP_SLL;
                    2'b01:   op = lc4_pkg::OP_SRA;
                    2'b10:   op = lc4_pkg::OP_SRL;
                    // MOD is not implemented
                    default: op = lc4_pkg::OP_NOP;
                endcase
            end
            default: op = lc4_pkg::OP_NOP;
        endcase
    end

    always_comb begin
        o_uop.valid  = 1'b1;
        o_uop.pc     = i_pc;
        o_uop.insn   = i_insn;
        o_uop.rd     = i_insn[11:9];
        // HICONST merges into its own destination, so it reads rd as rs
        o_uop.rs     = (op == lc4_pkg::OP_HICONST) ? i_insn[11:9] : i_insn[8:6];
        o_uop.rt     = i_insn[2:0];
        o_uop.rs_re  = (op != lc4_pkg::OP_NOP) && (op != lc4_pkg::OP_CONST);
        o_uop.rt_re  = (op == lc4_pkg::OP_ADD) || (op == lc4_pkg::OP_MUL) ||
                       (op == lc4_pkg::OP_SUB) || (op == lc4_pkg::OP_AND) ||
                       (op == lc4_pkg::OP_OR)  || (op == lc4_pkg::OP_XOR);
        // every kept operation writes rd
        o_uop.rd_we  = (op != lc4_pkg::OP_NOP);
        o_uop.alu_op = op;
    end

endmodule

`default_nettype wire

/* src/lc4_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_alu (
    input  wire lc4_pkg::alu_op_e         i_op,
    input  wire logic [lc4_pkg::XLEN-1:0] i_insn,
    input  wire logic [lc4_pkg::XLEN-1:0] i_rs,
    input  wire logic [lc4_pkg::XLEN-1:0] i_rt,
    output logic      [lc4_pkg::XLEN-1:0] o_result
);

    logic [lc4_pkg::XLEN-1:0] imm5_sext;
    logic [lc4_pkg::XLEN-1:0] imm9_sext;
    logic [3:0]               shamt;

    assign imm5_sext = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm9_sext = {{7{i_insn[8]}}, i_insn[8:0]};
    assign shamt     = i_insn[3:0];

    // all arithmetic wraps at 16 bits
    always_comb begin
        case (i_op)
            lc4_pkg::OP_ADD:     o_result = i_rs + i_rt;
            lc4_pkg::OP_MUL:     o_result = i_rs * i_rt;
            lc4_pkg::OP_SUB:     o_result = i_rs - i_rt;
            lc4_pkg::OP_ADDI:    o_result = i_rs + imm5_sext;
            lc4_pkg::OP_AND:     o_result = i_rs & i_rt;
            lc4_pkg::OP_NOT:     o_result = ~i_rs;
            lc4_pkg::OP_OR:      o_result = i_rs | i_rt;
            lc4_pkg::OP_XOR:     o_result = i_rs ^ i_rt;
            lc4_pkg::OP_ANDI:    o_result = i_rs & imm5_sext;
            lc4_pkg::OP_CONST:   o_result = imm9_sext;
            // new high byte over the old low byte
            lc4_pkg::OP_HICONST: o_result = {i_insn[7:0], i_rs[7:0]};
            lc4_pkg::OP_SLL:     o_result = i_rs << shamt;
            lc4_pkg::OP_SRA:     o_result = $signed(i_rs) >>> shamt;
            lc4_pkg::OP_SRL:     o_result = i_rs >> shamt;
            default:             o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/lc4_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_issue (
    input  wire logic                     gwe,
    input  wire logic                     i_rst_n,
    input  wire logic [lc4_pkg::XLEN-1:0] i_insn_a,
    input  wire logic [lc4_pkg::XLEN-1:0] i_insn_b,
    output logic      [lc4_pkg::XLEN-1:0] o_pc,
    output lc4_pkg::uop_t                 o_uop_a,
    output lc4_pkg::uop_t                 o_uop_b
);

    logic [lc4_pkg::XLEN-1:0] pc_q;
    logic [lc4_pkg::XLEN-1:0] pc_plus_one;
    logic [lc4_pkg::XLEN-1:0] pc_next;
    lc4_pkg::uop_t            uop_a;
    lc4_pkg::uop_t            uop_b;
    logic                     split;

    assign pc_plus_one = pc_q + 1'b1;

    // slot A sits at the PC, slot B right behind it
    lc4_decoder dec_a (
        .i_insn (i_insn_a),
        .i_pc   (pc_q),
        .o_uop  (uop_a)
    );

    lc4_decoder dec_b (
        .i_insn (i_insn_b),
        .i_pc   (pc_plus_one),
        .o_uop  (uop_b)
    );

    // B cannot see A's result in the same cycle, so hold it back
    assign split = uop_a.rd_we &&
                   ((uop_b.rs_re && (uop_b.rs == uop_a.rd)) ||
                    (uop_b.rt_re && (uop_b.rt == uop_a.rd)));

    // a held back B becomes slot A of the next pair
    assign pc_next = split ? pc_plus_one : pc_plus_one + 1'b1;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc_q <= lc4_pkg::RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    always_comb begin
        o_uop_a       = uop_a;
        o_uop_b       = uop_b;
        o_uop_b.valid = uop_b.valid & ~split;
    end

    assign o_pc = pc_q;

endmodule

`default_nettype wire

/* src/lc4_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile (
    input  wire logic                       gwe,
    input  wire logic                       i_rst_n,
    input  wire logic [lc4_pkg::REG_AW-1:0] i_rs_a,
    input  wire logic [lc4_pkg::REG_AW-1:0] i_rt_a,
    input  wire logic [lc4_pkg::REG_AW-1:0] i_rs_b,
    input  wire logic [lc4_pkg::REG_AW-1:0] i_rt_b,
    output logic      [lc4_pkg::XLEN-1:0]   o_rs_a,
    output logic      [lc4_pkg::XLEN-1:0]   o_rt_a,
    output logic      [lc4_pkg::XLEN-1:0]   o_rs_b,
    output logic      [lc4_pkg::XLEN-1:0]   o_rt_b,
    input  wire lc4_pkg::retire_t           i_wr_a,
    input  wire lc4_pkg::retire_t           i_wr_b
);

    logic [lc4_pkg::XLEN-1:0] regs [lc4_pkg::NUM_REGS];

    // newest value of a register, B before A before the array
    function automatic logic [lc4_pkg::XLEN-1:0] read_port(
        input logic [lc4_pkg::REG_AW-1:0] sel
    );
        logic [lc4_pkg::XLEN-1:0] val;
        val = regs[sel];
        if (i_wr_a.valid && i_wr_a.rd_we && (i_wr_a.rd == sel)) begin
            val = i_wr_a.data;
        end
        if (i_wr_b.valid && i_wr_b.rd_we && (i_wr_b.rd == sel)) begin
            val = i_wr_b.data;
        end
        return val;
    endfunction

    // lane B is younger, so its write lands last
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_wr_a.valid && i_wr_a.rd_we) begin
                regs[i_wr_a.rd] <= i_wr_a.data;
            end
            if (i_wr_b.valid && i_wr_b.rd_we) begin
                regs[i_wr_b.rd] <= i_wr_b.data;
            end
        end
    end

    always_comb begin
        o_rs_a = read_port(i_rs_a);
        o_rt_a = read_port(i_rt_a);
        o_rs_b = read_port(i_rs_b);
        o_rt_b = read_port(i_rt_b);
    end

endmodule

`default_nettype wire

/* src/lc4_exec_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_exec_lane (
    input  wire logic                     gwe,
    input  wire logic                     i_rst_n,
    input  wire lc4_pkg::uop_t            i_uop,
    input  wire logic [lc4_pkg::XLEN-1:0] i_rs_data,
    input  wire logic [lc4_pkg::XLEN-1:0] i_rt_data,
    input  wire lc4_pkg::retire_t         i_fwd_a,
    input  wire lc4_pkg::retire_t         i_fwd_b,
    output lc4_pkg::retire_t              o_retire
);

    lc4_pkg::uop_t            ex_uop;
    logic [lc4_pkg::XLEN-1:0] ex_rs_q;
    logic [lc4_pkg::XLEN-1:0] ex_rt_q;
    logic [lc4_pkg::XLEN-1:0] rs_val;
    logic [lc4_pkg::XLEN-1:0] rt_val;
    logic [lc4_pkg::XLEN-1:0] alu_result;

    // the pair in writeback is one pair older than this one
    function automatic logic [lc4_pkg::XLEN-1:0] fwd_operand(
        input logic [lc4_pkg::REG_AW-1:0] sel,
        input logic [lc4_pkg::XLEN-1:0]   rf_val,
        input lc4_pkg::retire_t           wb_a,
        input lc4_pkg::retire_t           wb_b
    );
        if (wb_b.valid && wb_b.rd_we && (wb_b.rd == sel)) begin
            return wb_b.data;
        end else if (wb_a.valid && wb_a.rd_we && (wb_a.rd == sel)) begin
            return wb_a.data;
        end
        return rf_val;
    endfunction

    // execute register
    always_ff @(posedge gwe) begin
        ex_uop  <= i_uop;
        ex_rs_q <= i_rs_data;
        ex_rt_q <= i_rt_data;
        if (!i_rst_n) begin
            ex_uop.valid <= 1'b0;
        end
    end

    always_comb begin
        rs_val = fwd_operand(ex_uop.rs, ex_rs_q, i_fwd_a, i_fwd_b);
        rt_val = fwd_operand(ex_uop.rt, ex_rt_q, i_fwd_a, i_fwd_b);
    end

    lc4_alu alu (
        .i_op     (ex_uop.alu_op),
        .i_insn   (ex_uop.insn),
        .i_rs     (rs_val),
        .i_rt     (rt_val),
        .o_result (alu_result)
    );

    // writeback register
    always_ff @(posedge gwe) begin
        o_retire.pc    <= ex_uop.pc;
        o_retire.insn  <= ex_uop.insn;
        o_retire.rd    <= ex_uop.rd;
        o_retire.rd_we <= ex_uop.valid & ex_uop.rd_we;
        o_retire.data  <= alu_result;
        if (!i_rst_n) begin
            o_retire.valid <= 1'b0;
        end else begin
            o_retire.valid <= ex_uop.valid;
        end
    end

endmodule

`default_nettype wire

/* src/lc4_superscalar.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_superscalar (
    input  wire logic                     gwe,
    input  wire logic                     i_rst_n,
    output logic      [lc4_pkg::XLEN-1:0] o_pc,
    input  wire logic [lc4_pkg::XLEN-1:0] i_insn_a,
    input  wire logic [lc4_pkg::XLEN-1:0] i_insn_b,
    output lc4_pkg::retire_t              o_retire_a,
    output lc4_pkg::retire_t              o_retire_b
);

    lc4_pkg::uop_t            uop_a;
    lc4_pkg::uop_t            uop_b;
    logic [lc4_pkg::XLEN-1:0] rs_data_a;
    logic [lc4_pkg::XLEN-1:0] rt_data_a;
    logic [lc4_pkg::XLEN-1:0] rs_data_b;
    logic [lc4_pkg::XLEN-1:0] rt_data_b;
    lc4_pkg::retire_t         retire_a;
    lc4_pkg::retire_t         retire_b;

    // fetch and decode, one or two uops per cycle
    lc4_issue issue (
        .gwe      (gwe),
        .i_rst_n  (i_rst_n),
        .i_insn_a (i_insn_a),
        .i_insn_b (i_insn_b),
        .o_pc     (o_pc),
        .o_uop_a  (uop_a),
        .o_uop_b  (uop_b)
    );

    // operands are read during decode, write-through covers the writeback pair
    lc4_regfile regfile (
        .gwe     (gwe),
        .i_rst_n (i_rst_n),
        .i_rs_a  (uop_a.rs),
        .i_rt_a  (uop_a.rt),
        .i_rs_b  (uop_b.rs),
        .i_rt_b  (uop_b.rt),
        .o_rs_a  (rs_data_a),
        .o_rt_a  (rt_data_a),
        .o_rs_b  (rs_data_b),
        .o_rt_b  (rt_data_b),
        .i_wr_a  (retire_a),
        .i_wr_b  (retire_b)
    );

    // both lanes forward from the same pair of writeback registers
    lc4_exec_lane lane_a (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_uop     (uop_a),
        .i_rs_data (rs_data_a),
        .i_rt_data (rt_data_a),
        .i_fwd_a   (retire_a),
        .i_fwd_b   (retire_b),
        .o_retire  (retire_a)
    );

    lc4_exec_lane lane_b (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_uop     (uop_b),
        .i_rs_data (rs_data_b),
        .i_rt_data (rt_data_b),
        .i_fwd_a   (retire_a),
        .i_fwd_b   (retire_b),
        .o_retire  (retire_b)
    );

    assign o_retire_a = retire_a;
    assign o_retire_b = retire_b;

endmodule

`default_nettype wire

/* verification/tb_lc4_model.svh */
`ifndef TB_LC4_MODEL_SVH
`define TB_LC4_MODEL_SVH

// Galois LFSR stepped once per random bit
function automatic logic lfsr_step();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ LFSR_TAPS;
    end
    return out_bit;
endfunction

function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val = {val[14:0], lfsr_step()};
    end
    return val;
endfunction

// three of four picks stay in r0..r3 so that pairs collide often
function automatic logic [2:0] pick_reg();
    logic [15:0] r;
    r = rand_bits(2);
    if (r[1:0] != 2'b00) begin
        r = rand_bits(2);
    end else begin
        r = rand_bits(3);
    end
    return r[2:0];
endfunction

// BR, DIV, MOD and CMP encodings that write nothing
function automatic logic [15:0] nop_insn();
    logic [15:0] r;
    r = rand_bits(14);
    case (r[13:12])
        2'b00:   return {4'b0000, r[11:0]};
        2'b01:   return {4'b0001, r[11:6], 3'b011, r[2:0]};
        2'b10:   return {4'b1010, r[11:6], 2'b11, r[3:0]};
        default: return {4'b0010, r[11:0]};
    endcase
endfunction

function automatic logic [15:0] random_insn();
    logic [15:0] kind;
    logic [2:0]  rd;
    logic [2:0]  rs;
    logic [2:0]  rt;
    logic [15:0] imm;
    kind = rand_bits(4);
    rd   = pick_reg();
    rs   = pick_reg();
    rt   = pick_reg();
    imm  = rand_bits(9);
    case (kind[3:0])
        4'd0:    return {4'b0001, rd, rs, 3'b000, rt};
        4'd1:    return {4'b0001, rd, rs, 3'b001, rt};
        4'd2:    return {4'b0001, rd, rs, 3'b010, rt};
        4'd3:    return {4'b0001, rd, rs, 1'b1, imm[4:0]};
        4'd4:    return {4'b0101, rd, rs, 3'b000, rt};
        4'd5:    return {4'b0101, rd, rs, 3'b001, rt};
        4'd6:    return {4'b0101, rd, rs, 3'b010, rt};
        4'd7:    return {4'b0101, rd, rs, 3'b011, rt};
        4'd8:    return {4'b0101, rd, rs, 1'b1, imm[4:0]};
        4'd9:    return {4'b1001, rd, imm[8:0]};
        4'd10:   return {4'b1101, rd, 1'b1, imm[7:0]};
        4'd11:   return {4'b1010, rd, rs, 2'b00, imm[3:0]};
        4'd12:   return {4'b1010, rd, rs, 2'b01, imm[3:0]};
        4'd13:   return {4'b1010, rd, rs, 2'b10, imm[3:0]};
        default: return nop_insn();
    endcase
endfunction

task automatic build_program();
    lfsr_state = LFSR_SEED;
    // independent pair then forwarding into both lanes
    prog[0] = {4'b1001, 3'd1, 9'd5};                  // CONST R1, #5
    prog[1] = {4'b1001, 3'd2, 9'h1FD};                // CONST R2, #-3
    prog[2] = {4'b0001, 3'd3, 3'd1, 3'b000, 3'd2};    // ADD R3, R1, R2
    prog[3] = {4'b0001, 3'd5, 3'd2, 3'b010, 3'd1};    // SUB R5, R2, R1
    // both slots write R6 and the reader must see the younger value
    prog[4] = {4'b1001, 3'd6, 9'd1};
    prog[5] = {4'b1001, 3'd6, 9'd2};
    prog[6] = {4'b0001, 3'd7, 3'd6, 3'b000, 3'd6};
    prog[7] = {4'b0101, 3'd0, 3'd3, 3'b000, 3'd5};
    // dependent pair that has to split
    prog[8] = {4'b0001, 3'd4, 3'd7, 3'b000, 3'd7};
    prog[9] = {4'b0001, 3'd5, 3'd4, 3'b000, 3'd4};
    for (int k = HEAD_LEN; k < PROG_LEN; k++) begin
        prog[k] = random_insn();
    end
endtask

// LC4 semantics of one instruction against the model register file
function automatic logic [15:0] reference_result(
    input  logic [15:0] insn,
    output logic        writes
);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    a      = model_regs[insn[8:6]];
    b      = model_regs[insn[2:0]];
    res    = '0;
    writes = 1'b1;
    case (insn[15:12])
        4'b0001: begin
            if (insn[5]) begin
                res = a + {{11{insn[4]}}, insn[4:0]};
            end else if (insn[4:3] == 2'b00) begin
                res = a + b;
            end else if (insn[4:3] == 2'b01) begin
                res = a * b;
            end else if (insn[4:3] == 2'b10) begin
                res = a - b;
            end else begin
                writes = 1'b0;
            end
        end
        4'b0101: begin
            if (insn[5]) begin
                res = a & {{11{insn[4]}}, insn[4:0]};
            end else begin
                case (insn[4:3])
                    2'b00:   res = a & b;
                    2'b01:   res = ~a;
                    2'b10:   res = a | b;
                    default: res = a ^ b;
                endcase
            end
        end
        4'b1001: res = {{7{insn[8]}}, insn[8:0]};
        4'b1101: res = (model_regs[insn[11:9]] & 16'h00FF) | {insn[7:0], 8'h00};
        4'b1010: begin
            case (insn[5:4])
                2'b00:   res = a << insn[3:0];
                2'b01:   res = $unsigned($signed(a) >>> insn[3:0]);
                2'b10:   res = a >> insn[3:0];
                default: writes = 1'b0;
            endcase
        end
        default: writes = 1'b0;
    endcase
    return res;
endfunction

// register reads as LC4 defines them where HICONST reads its own destination
function automatic logic reads_reg(input logic [15:0] insn, input logic [2:0] r);
    logic rs_hit;
    logic rt_hit;
    rs_hit = (insn[8:6] == r);
    rt_hit = (insn[2:0] == r);
    case (insn[15:12])
        4'b0001: return insn[5] ? rs_hit : ((insn[4:3] != 2'b11) && (rs_hit || rt_hit));
        4'b0101: return (insn[5] || insn[4:3] == 2'b01) ? rs_hit : (rs_hit || rt_hit);
        4'b1101: return (insn[11:9] == r);
        4'b1010: return (insn[5:4] != 2'b11) && rs_hit;
        default: return 1'b0;
    endcase
endfunction

task automatic build_expected();
    logic [15:0] data;
    logic        writes;
    for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
    for (int k = 0; k < PROG_LEN; k++) begin
        data              = reference_result(prog[k], writes);
        expected[k].valid = 1'b1;
        expected[k].pc    = lc4_pkg::RESET_PC + 16'(k);
        expected[k].insn  = prog[k];
        expected[k].rd    = prog[k][11:9];
        expected[k].rd_we = writes;
        expected[k].data  = data;
        if (writes) begin
            model_regs[prog[k][11:9]] = data;
        end
    end
endtask

task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

`endif

/* verification/tb_lc4_superscalar.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_superscalar;

    localparam int          PROG_LEN           = 200;
    localparam int          HEAD_LEN           = 10;
    localparam int          TIMEOUT_CYCLES     = 3 * PROG_LEN + 50;
    // fetch cycle plus two
    localparam int          FIRST_RETIRE_CYCLE = 3;
    localparam logic [31:0] LFSR_SEED          = 32'd83836;
    localparam logic [31:0] LFSR_TAPS          = 32'h8020_0003;

    logic                     gwe;
    logic                     i_rst_n;
    logic [lc4_pkg::XLEN-1:0] o_pc;
    logic [lc4_pkg::XLEN-1:0] i_insn_a;
    logic [lc4_pkg::XLEN-1:0] i_insn_b;
    lc4_pkg::retire_t         o_retire_a;
    lc4_pkg::retire_t         o_retire_b;

    logic [15:0]              prog [PROG_LEN];
    lc4_pkg::retire_t         expected [PROG_LEN];
    logic [15:0]              model_regs [lc4_pkg::NUM_REGS];
    logic [31:0]              lfsr_state;
    int                       retired;
    int                       mismatch_count;
    int                       other_errors;
    int                       cycles;

    lc4_superscalar uut (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .o_pc       (o_pc),
        .i_insn_a   (i_insn_a),
        .i_insn_b   (i_insn_b),
        .o_retire_a (o_retire_a),
        .o_retire_b (o_retire_b)
    );

    initial begin
        gwe = 1'b0;
        forever begin
            #2 gwe = ~gwe;
        end
    end

    // program at RESET_PC, a BR word folded from the address everywhere else
    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        logic [15:0] offset;
        offset = addr - lc4_pkg::RESET_PC;
        if (int'(offset) < PROG_LEN) begin
            return prog[int'(offset)];
        end
        return {4'b0000, addr[11:0] ^ {8'h00, addr[15:12]}};
    endfunction

    always_comb begin
        i_insn_a = fetch_word(o_pc);
        i_insn_b = fetch_word(o_pc + 16'd1);
    end

    initial begin
        i_rst_n        = 1'b0;
        retired        = 0;
        mismatch_count = 0;
        other_errors   = 0;
        build_program();
        build_expected();
        repeat (8) begin
            @(posedge gwe);
        end
        i_rst_n <= 1'b1;
    end

    task automatic compare_retire(input string lane, input lc4_pkg::retire_t got);
        lc4_pkg::retire_t exp;
        // anything past the program end is fill and is not checked
        if (retired < PROG_LEN) begin
            exp = expected[retired];
            check_value({lane, ".pc"}, got.pc, exp.pc);
            check_value({lane, ".insn"}, got.insn, exp.insn);
            check_value({lane, ".rd_we"}, 16'(got.rd_we), 16'(exp.rd_we));
            check_value({lane, ".data"}, got.data, exp.data);
            if (exp.rd_we) begin
                check_value({lane, ".rd"}, 16'(got.rd), 16'(exp.rd));
            end
            retired++;
        end
    endtask

    task automatic report_and_finish();
        $display("summary: %0d of %0d retired, %0d value mismatches, %0d other errors",
                 retired, PROG_LEN, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // lane A always holds the older instruction of a retiring pair
    initial begin : retire_check
        int          rel;
        logic        pair_expected;
        logic [15:0] next_word;
        rel = 0;
        wait (i_rst_n === 1'b1);
        while (retired < PROG_LEN) begin
            @(negedge gwe);
            rel++;
            if (rel < FIRST_RETIRE_CYCLE) begin
                check_value("o_retire_a.valid", 16'(o_retire_a.valid), 16'd0);
                check_value("o_retire_b.valid", 16'(o_retire_b.valid), 16'd0);
            end else if (rel == FIRST_RETIRE_CYCLE) begin
                check_value("o_retire_a.valid", 16'(o_retire_a.valid), 16'd1);
            end
            if (o_retire_a.valid) begin
                // slot B shares the cycle unless it reads what slot A writes
                next_word     = fetch_word(expected[retired].pc + 16'd1);
                pair_expected = !(expected[retired].rd_we &&
                                  reads_reg(next_word, expected[retired].rd));
                compare_retire("o_retire_a", o_retire_a);
                check_value("o_retire_b.valid", 16'(o_retire_b.valid), 16'(pair_expected));
                if (o_retire_b.valid) begin
                    compare_retire("o_retire_b", o_retire_b);
                end
            end else begin
                check_value("o_retire_b.valid", 16'(o_retire_b.valid), 16'd0);
            end
        end
        report_and_finish();
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge gwe);
            cycles++;
        end
        $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                 retired, PROG_LEN, cycles);
        other_errors++;
        report_and_finish();
    end

    `include "tb_lc4_model.svh"

endmodule

`default_nettype wire

/* project.f */
+incdir+verification
src/lc4_pkg.sv
src/lc4_decoder.sv
src/lc4_alu.sv
src/lc4_issue.sv
src/lc4_regfile.sv
src/lc4_exec_lane.sv
src/lc4_superscalar.sv
verification/tb_lc4_superscalar.sv

/* run.sh */
#!/bin/sh
# build and run the LC4 two-wide pipeline regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_lc4_superscalar -f project.f \
    && ./obj_dir/Vtb_lc4_superscalar > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Regression passed$" sim.log \
    && { echo "simulation PASS"; exit 0; } \
    || { echo "simulation FAIL"; exit 1; }
